/* files.f */
hw/feature_pkg.sv
hw/sp_ram.sv
hw/row_mem_arbiter.sv
hw/axil_regs.sv
hw/binomial_blur.sv
hw/kpt_detect.sv
hw/feature_core.sv
sim/tb_feature_core.sv

/* Makefile */
# Verilator build and run for the feature detection core

VERILATOR ?= verilator
TOP       ?= tb_feature_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= No errors

SRCS := $(wildcard hw/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_feature_core.sv */
`timescale 1ns/100ps

module tb_feature_core;

    localparam int RUN_CYCLES = 1500;                  // load, run and readback of one image
    localparam int TIMEOUT    = 8 * RUN_CYCLES;        // seven runs plus reset and row tests

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           awvalid;
    logic                           awready;
    logic [feature_pkg::AXI_AW-1:0] awaddr;
    logic                           wvalid;
    logic                           wready;
    logic [feature_pkg::AXI_DW-1:0] wdata;
    logic                           bvalid;
    logic                           bready;
    logic [1:0]                     bresp;
    logic                           arvalid;
    logic                           arready;
    logic [feature_pkg::AXI_AW-1:0] araddr;
    logic                           rvalid;
    logic                           rready;
    logic [feature_pkg::AXI_DW-1:0] rdata;
    logic [1:0]                     rresp;

    logic [7:0]        img [16][16];                   // model image, [row][col]
    feature_pkg::kpt_t exp_kpt [$];
    int                errors = 0;
    int                checks = 0;
    int                tests  = 0;
    int                cycles = 0;
    integer            seed;

    feature_core i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout: simulation still running after %0d cycles", TIMEOUT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_row(input string what, input feature_pkg::row_t got,
                             input feature_pkg::row_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_kpt(input string what, input feature_pkg::kpt_t got,
                             input feature_pkg::kpt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got (%0d,%0d), expected (%0d,%0d)", $time, what,
                     got[7:4], got[3:0], exp[7:4], exp[3:0]);
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(posedge clk);
        while (!awready) @(posedge clk);               // awready and wready rise together
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        check_word("write response", {30'd0, bresp}, 32'd0);
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        data = rdata;
        check_word("read response", {30'd0, rresp}, 32'd0);
    endtask

    function automatic logic [11:0] row_addr(input int a, input int l);
        return feature_pkg::ROW_WIN + 12'(16 * a + 4 * l);
    endfunction

    task automatic write_row(input int a, input feature_pkg::row_t data);
        for (int l = 0; l < 4; l++)
            axi_write(row_addr(a, l), data[32*l +: 32]);  // lane 3 commits the row
    endtask

    task automatic read_row(input int a, output feature_pkg::row_t data);
        logic [31:0] lane;
        for (int l = 0; l < 4; l++) begin
            axi_read(row_addr(a, l), lane);
            data[32*l +: 32] = lane;
        end
    endtask

    function automatic feature_pkg::row_t pack_row(input int r);
        feature_pkg::row_t row;
        for (int c = 0; c < 16; c++)
            row[8*c +: 8] = img[r][c];
        return row;
    endfunction

    // 1-2-1 by 1-2-1 with zeros outside the image
    function automatic logic [7:0] blur_px(input int r, input int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                if (r + dr >= 0 && r + dr < 16 && c + dc >= 0 && c + dc < 16)
                    sum += w * int'(img[r+dr][c+dc]);
            end
        end
        return 8'(sum / 16);
    endfunction

    function automatic feature_pkg::row_t blur_row(input int r);
        feature_pkg::row_t row;
        for (int c = 0; c < 16; c++)
            row[8*c +: 8] = blur_px(r, c);
        return row;
    endfunction

    task automatic model_kpts(input int thresh);
        int diff;
        exp_kpt.delete();
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                diff = int'(img[r][c]) - int'(blur_px(r, c));
                if (diff < 0)
                    diff = -diff;
                if (diff > thresh && exp_kpt.size() < feature_pkg::KPT_DEPTH)
                    exp_kpt.push_back(feature_pkg::kpt_t'({4'(r), 4'(c)}));
            end
        end
    endtask

    task automatic random_image();
        for (int r = 0; r < 16; r++)
            for (int c = 0; c < 16; c++)
                img[r][c] = 8'($random(seed));
    endtask

    task automatic load_image();
        for (int r = 0; r < 16; r++)
            write_row(r, pack_row(r));
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (status[1] == 1'b0 && polls < RUN_CYCLES / 4) begin
            axi_read(feature_pkg::REG_STATUS, status);
            polls++;
        end
        if (status[1] == 1'b0) begin
            errors++;
            $display("run did not finish: STATUS never showed done after %0d polls", polls);
        end else begin
            check_word("STATUS after run", status, 32'h2);
        end
    endtask

    task automatic run_core();
        axi_write(feature_pkg::REG_CTRL, 32'h1);
        wait_done();
    endtask

    task automatic check_blur();
        feature_pkg::row_t got;
        for (int r = 0; r < 16; r++) begin
            read_row(feature_pkg::BLUR_BASE + r, got);
            check_row($sformatf("blurred row %0d", r), got, blur_row(r));
        end
    endtask

    task automatic check_kpts();
        logic [31:0] data;
        axi_read(feature_pkg::REG_KPT_CNT, data);
        check_word("KPT_CNT", data, 32'(exp_kpt.size()));
        foreach (exp_kpt[i]) begin
            axi_read(feature_pkg::KPT_WIN + 12'(4 * i), data);
            check_kpt($sformatf("keypoint %0d", i), data[7:0], exp_kpt[i]);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("%0t %s: ok", $time, name);
        else
            $display("%0t %s: %0d mismatches", $time, name, errors - errs_before);
    endtask

    task automatic test_reset();
        logic [31:0] data;
        int          e0;
        e0 = errors;
        check_word("handshake outputs after reset",
                   {27'd0, awready, wready, arready, bvalid, rvalid}, '0);
        axi_read(feature_pkg::REG_STATUS, data);
        check_word("STATUS after reset", data, '0);
        axi_read(feature_pkg::REG_KPT_CNT, data);
        check_word("KPT_CNT after reset", data, '0);
        end_test("after reset", e0);
    endtask

    task automatic test_row_load();
        int                rows [4] = '{0, 5, 10, 15};
        feature_pkg::row_t data [4];
        feature_pkg::row_t got;
        logic [31:0]       lane;
        int                e0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            for (int l = 0; l < 4; l++)
                data[i][32*l +: 32] = $random(seed);
            write_row(rows[i], data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            for (int l = 0; l < 4; l++) begin
                axi_read(row_addr(rows[i], l), lane);
                check_word($sformatf("row %0d lane %0d", rows[i], l), lane, data[i][32*l +: 32]);
            end
        end
        for (int l = 0; l < 3; l++)
            axi_write(row_addr(5, l), ~data[1][32*l +: 32]);  // staged, never committed
        read_row(5, got);
        check_row("row 5 after staging lanes 0-2", got, data[1]);
        end_test("row load", e0);
    endtask

    task automatic test_blur();
        int e0;
        e0 = errors;
        random_image();
        load_image();
        run_core();
        check_blur();
        for (int r = 0; r < 16; r++)
            for (int c = 0; c < 16; c++)
                img[r][c] = 8'h00;
        img[0][15] = 8'hFF;                            // corner impulse, top and right edges
        load_image();
        run_core();
        check_blur();
        end_test("blur", e0);
    endtask

    task automatic test_detect();
        logic [31:0] data;
        int          e0;
        e0 = errors;
        random_image();
        load_image();
        axi_write(feature_pkg::REG_THRESH, 32'd100);
        axi_read(feature_pkg::REG_THRESH, data);
        check_word("THRESH readback", data, 32'd100);
        run_core();
        model_kpts(100);
        check_kpts();
        end_test("detection", e0);
    endtask

    task automatic test_bounds();
        logic [31:0] data;
        int          e0;
        e0 = errors;
        axi_write(feature_pkg::REG_THRESH, 32'd255);
        run_core();
        model_kpts(255);
        check_kpts();
        for (int r = 0; r < 16; r++)
            for (int c = 0; c < 16; c++)
                img[r][c] = ((r + c) % 2 == 1) ? 8'hFF : 8'h00;
        load_image();
        axi_write(feature_pkg::REG_THRESH, 32'd0);
        run_core();
        axi_read(feature_pkg::REG_KPT_CNT, data);
        check_word("checkerboard KPT_CNT", data, 32'd64);
        model_kpts(0);
        check_kpts();
        end_test("bounds", e0);
    endtask

    task automatic test_busy();
        logic [31:0] data;
        int          e0;
        e0 = errors;
        random_image();
        load_image();
        axi_write(feature_pkg::REG_THRESH, 32'd110);
        axi_write(feature_pkg::REG_CTRL, 32'h1);
        axi_read(feature_pkg::REG_STATUS, data);
        check_word("STATUS while running", data, 32'h1);
        axi_write(feature_pkg::REG_CTRL, 32'h1);      // ignored while busy
        axi_read(feature_pkg::REG_STATUS, data);
        check_word("STATUS after start while busy", data, 32'h1);
        wait_done();
        model_kpts(110);
        check_kpts();
        random_image();
        load_image();
        run_core();
        model_kpts(110);
        check_kpts();
        end_test("busy handling", e0);
    endtask

    initial begin
        seed    = 32'h9247_7465;
        rst_n   <= 1'b0;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        bready  <= 1'b1;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_row_load();
        test_blur();
        test_detect();
        test_bounds();
        test_busy();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* hw/feature_core.sv */
`timescale 1ns/100ps

module feature_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [feature_pkg::AXI_AW-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [feature_pkg::AXI_DW-1:0] wdata,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [feature_pkg::AXI_AW-1:0] araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [feature_pkg::AXI_DW-1:0] rdata,
    output logic [1:0]                     rresp
);

    logic [feature_pkg::N_REQ-1:0] req;
    logic [feature_pkg::N_REQ-1:0] req_we;
    logic [feature_pkg::N_REQ-1:0] gnt;
    feature_pkg::row_addr_t        req_addr [feature_pkg::N_REQ];
    feature_pkg::row_t             req_wdata [feature_pkg::N_REQ];
    feature_pkg::row_t             mem_rdata;
    logic                          blur_start;
    logic                          blur_done;
    logic                          detect_start;
    logic                          detect_done;
    logic [7:0]                    thresh;
    feature_pkg::kpt_cnt_t         kpt_cnt;
    logic [feature_pkg::KPT_AW-1:0] kpt_raddr;
    feature_pkg::kpt_t             kpt_rdata;

    assign req_we[2]    = 1'b0;                        // detector only reads
    assign req_wdata[2] = '0;

    axil_regs i_regs (
        .*,
        .mem_req   (req[0]),
        .mem_we    (req_we[0]),
        .mem_addr  (req_addr[0]),
        .mem_wdata (req_wdata[0]),
        .mem_gnt   (gnt[0])
    );

    binomial_blur i_blur (
        .*,
        .start     (blur_start),
        .done      (blur_done),
        .mem_req   (req[1]),
        .mem_we    (req_we[1]),
        .mem_addr  (req_addr[1]),
        .mem_wdata (req_wdata[1]),
        .mem_gnt   (gnt[1])
    );

    kpt_detect i_detect (
        .*,
        .start    (detect_start),
        .done     (detect_done),
        .mem_req  (req[2]),
        .mem_addr (req_addr[2]),
        .mem_gnt  (gnt[2])
    );

    row_mem_arbiter i_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .we    (req_we),
        .addr  (req_addr),
        .wdata (req_wdata),
        .gnt   (gnt),
        .rdata (mem_rdata)
    );

endmodule

/* hw/kpt_detect.sv */
`timescale 1ns/100ps

module kpt_detect (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    output logic                           done,
    input  logic [7:0]                     thresh,
    output logic                           mem_req,
    output feature_pkg::row_addr_t         mem_addr,
    input  logic                           mem_gnt,
    input  feature_pkg::row_t              mem_rdata,
    output feature_pkg::kpt_cnt_t          kpt_cnt,
    input  logic [feature_pkg::KPT_AW-1:0] kpt_raddr,
    output feature_pkg::kpt_t              kpt_rdata
);

    typedef enum logic [1:0] {K_IDLE, K_RD, K_CAP, K_SCAN} k_state_t;

    k_state_t          state;
    logic              phase;                          // 0 image row, 1 blurred row
    logic [3:0]        row;
    logic [3:0]        col;
    feature_pkg::row_t orig;
    feature_pkg::row_t blr;
    logic [7:0]        pix_a;
    logic [7:0]        pix_b;
    logic [7:0]        diff;
    logic              kpt_we;

    assign pix_a    = orig[col*feature_pkg::PIX_W +: feature_pkg::PIX_W];
    assign pix_b    = blr[col*feature_pkg::PIX_W +: feature_pkg::PIX_W];
    assign diff     = (pix_a > pix_b) ? pix_a - pix_b : pix_b - pix_a;
    assign kpt_we   = state == K_SCAN && diff > thresh && kpt_cnt < feature_pkg::KPT_DEPTH;
    assign mem_req  = state == K_RD;
    assign mem_addr = phase ? feature_pkg::row_addr_t'(feature_pkg::BLUR_BASE + row) :
                              feature_pkg::row_addr_t'(row);

    sp_ram #(
        .word_t (feature_pkg::kpt_t),
        .DEPTH  (feature_pkg::KPT_DEPTH)
    ) i_kpt_ram (
        .clk   (clk),
        .we    (kpt_we),
        .addr  (kpt_we ? kpt_cnt[feature_pkg::KPT_AW-1:0] : kpt_raddr),
        .wdata ({row, col}),
        .rdata (kpt_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= K_IDLE;
            done    <= 1'b0;
            phase   <= 1'b0;
            row     <= '0;
            col     <= '0;
            kpt_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                K_IDLE: begin
                    if (start) begin
                        kpt_cnt <= '0;
                        row     <= '0;
                        phase   <= 1'b0;
                        state   <= K_RD;
                    end
                end
                K_RD: begin
                    if (mem_gnt)
                        state <= K_CAP;
                end
                K_CAP: begin
                    phase <= ~phase;
                    col   <= '0;
                    state <= phase ? K_SCAN : K_RD;
                end
                K_SCAN: begin
                    if (kpt_we)
                        kpt_cnt <= kpt_cnt + 1'b1;     // stops at 64
                    col <= col + 4'd1;
                    if (col == feature_pkg::IMG_W - 1) begin
                        row <= row + 4'd1;
                        if (row == feature_pkg::IMG_H - 1) begin
                            done  <= 1'b1;
                            state <= K_IDLE;
                        end else begin
                            state <= K_RD;
                        end
                    end
                end
                default: state <= K_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == K_CAP) begin
            if (phase)
                blr <= mem_rdata;
            else
                orig <= mem_rdata;
        end
    end

endmodule

/* hw/binomial_blur.sv */
`timescale 1ns/100ps

module binomial_blur (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   done,
    output logic                   mem_req,
    output logic                   mem_we,
    output feature_pkg::row_addr_t mem_addr,
    output feature_pkg::row_t      mem_wdata,
    input  logic                   mem_gnt,
    input  feature_pkg::row_t      mem_rdata
);

    typedef enum logic [1:0] {B_IDLE, B_FETCH, B_CAP, B_WR} b_state_t;

    b_state_t          state;
    logic [4:0]        fetch;                          // next image row to shift in
    feature_pkg::row_t top;
    feature_pkg::row_t mid;
    feature_pkg::row_t bot;
    logic [9:0]        vsum [feature_pkg::IMG_W+2];    // zero column at each end
    logic              past_img;

    assign past_img = fetch >= feature_pkg::IMG_H;
    assign mem_req  = (state == B_FETCH && !past_img) || state == B_WR;
    assign mem_we   = state == B_WR;
    assign mem_addr = (state == B_WR) ?
                      feature_pkg::row_addr_t'(feature_pkg::BLUR_BASE + fetch - 1) :
                      feature_pkg::row_addr_t'(fetch);

    // vertical 1-2-1
    always_comb begin
        vsum[0] = '0;
        vsum[feature_pkg::IMG_W+1] = '0;
        for (int c = 0; c < feature_pkg::IMG_W; c++) begin
            vsum[c+1] = 10'(top[c*feature_pkg::PIX_W +: feature_pkg::PIX_W])
                      + 10'({mid[c*feature_pkg::PIX_W +: feature_pkg::PIX_W], 1'b0})
                      + 10'(bot[c*feature_pkg::PIX_W +: feature_pkg::PIX_W]);
        end
    end

    // horizontal 1-2-1, then divide by 16
    always_comb begin
        logic [11:0] hsum;
        hsum = '0;
        mem_wdata = '0;
        for (int c = 0; c < feature_pkg::IMG_W; c++) begin
            hsum = 12'(vsum[c]) + 12'({vsum[c+1], 1'b0}) + 12'(vsum[c+2]);
            mem_wdata[c*feature_pkg::PIX_W +: feature_pkg::PIX_W] = hsum[11:4];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= B_IDLE;
            done  <= 1'b0;
            fetch <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (start) begin
                        fetch <= '0;
                        state <= B_FETCH;
                    end
                end
                B_FETCH: begin
                    if (past_img)
                        state <= B_WR;                 // zero row below the image
                    else if (mem_gnt)
                        state <= B_CAP;
                end
                B_CAP: begin
                    if (fetch == 5'd0) begin
                        fetch <= 5'd1;
                        state <= B_FETCH;
                    end else begin
                        state <= B_WR;
                    end
                end
                B_WR: begin
                    if (mem_gnt) begin
                        if (past_img) begin
                            done  <= 1'b1;
                            state <= B_IDLE;
                        end else begin
                            fetch <= fetch + 5'd1;
                            state <= B_FETCH;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // three-row window, zero above row 0
    always_ff @(posedge clk) begin
        if (state == B_IDLE && start) begin
            top <= '0;
            mid <= '0;
            bot <= '0;
        end else if (state == B_CAP || (state == B_FETCH && past_img)) begin
            top <= mid;
            mid <= bot;
            bot <= (state == B_CAP) ? mem_rdata : '0;
        end
    end

endmodule

/* hw/axil_regs.sv */
`timescale 1ns/100ps

module axil_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [feature_pkg::AXI_AW-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [feature_pkg::AXI_DW-1:0] wdata,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [feature_pkg::AXI_AW-1:0] araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [feature_pkg::AXI_DW-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           blur_start,
    output logic                           detect_start,
    input  logic                           blur_done,
    input  logic                           detect_done,
    output logic [7:0]                     thresh,
    input  feature_pkg::kpt_cnt_t          kpt_cnt,
    output logic [feature_pkg::KPT_AW-1:0] kpt_raddr,
    input  feature_pkg::kpt_t              kpt_rdata,
    output logic                           mem_req,
    output logic                           mem_we,
    output feature_pkg::row_addr_t         mem_addr,
    output feature_pkg::row_t              mem_wdata,
    input  logic                           mem_gnt,
    input  feature_pkg::row_t              mem_rdata
);

    typedef enum logic [2:0] {
        S_IDLE, S_WR, S_WMEM, S_BRESP, S_RD, S_RMEM, S_RCAP, S_RRESP
    } bus_state_t;
    typedef enum logic [1:0] {SQ_IDLE, SQ_BLUR, SQ_DETECT} seq_state_t;

    bus_state_t                     state;
    seq_state_t                     seq;
    logic [feature_pkg::AXI_DW-1:0] stage [3];         // lanes 0..2 of the next row
    logic [1:0]                     rd_lane;
    logic                           rd_kpt;
    logic                           busy;
    logic                           done;
    logic                           aw_row;
    logic                           ar_row;
    logic                           ar_kpt;
    logic                           start_wr;

    assign aw_row    = awaddr[11:9] == feature_pkg::ROW_WIN[11:9];
    assign ar_row    = araddr[11:9] == feature_pkg::ROW_WIN[11:9];
    assign ar_kpt    = araddr[11:8] == feature_pkg::KPT_WIN[11:8];
    assign start_wr  = state == S_WR && awaddr == feature_pkg::REG_CTRL && wdata[0];
    assign busy      = seq != SQ_IDLE;
    assign kpt_raddr = araddr[feature_pkg::KPT_AW+1:2]; // ram samples it at the handshake
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            thresh  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= S_WR;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                        state   <= S_RD;
                    end
                end
                S_WR: begin
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    if (aw_row && awaddr[3:2] == 2'd3) begin  // full row commit
                        mem_req <= 1'b1;
                        mem_we  <= 1'b1;
                        state   <= S_WMEM;
                    end else begin
                        if (awaddr == feature_pkg::REG_THRESH)
                            thresh <= wdata[7:0];
                        bvalid <= 1'b1;
                        state  <= S_BRESP;
                    end
                end
                S_RD: begin
                    arready <= 1'b0;
                    if (ar_row) begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= S_RMEM;
                    end else if (ar_kpt) begin
                        state <= S_RCAP;
                    end else begin
                        rvalid <= 1'b1;
                        state  <= S_RRESP;
                    end
                end
                S_WMEM, S_RMEM: begin
                    if (mem_gnt) begin
                        mem_req <= 1'b0;
                        if (state == S_WMEM) begin
                            bvalid <= 1'b1;
                            state  <= S_BRESP;
                        end else begin
                            state <= S_RCAP;
                        end
                    end
                end
                S_RCAP: begin
                    rvalid <= 1'b1;
                    state  <= S_RRESP;
                end
                S_BRESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                S_RRESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WR && aw_row) begin
            mem_addr <= awaddr[8:4];
            if (awaddr[3:2] == 2'd3)
                mem_wdata <= {wdata, stage[2], stage[1], stage[0]};
            else
                stage[awaddr[3:2]] <= wdata;
        end
        if (state == S_RD) begin
            mem_addr <= araddr[8:4];
            rd_lane  <= araddr[3:2];
            rd_kpt   <= ar_kpt;
            case (araddr)
                feature_pkg::REG_STATUS:  rdata <= {{(feature_pkg::AXI_DW-2){1'b0}}, done, busy};
                feature_pkg::REG_THRESH:  rdata <= {{(feature_pkg::AXI_DW-8){1'b0}}, thresh};
                feature_pkg::REG_KPT_CNT: rdata <= {{(feature_pkg::AXI_DW-7){1'b0}}, kpt_cnt};
                default:                  rdata <= '0;
            endcase
        end
        if (state == S_RCAP) begin
            if (rd_kpt)
                rdata <= {{(feature_pkg::AXI_DW-8){1'b0}}, kpt_rdata};
            else
                rdata <= mem_rdata[rd_lane*feature_pkg::AXI_DW +: feature_pkg::AXI_DW];
        end
    end

    // run sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq          <= SQ_IDLE;
            done         <= 1'b0;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
        end else begin
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            case (seq)
                SQ_IDLE: begin
                    if (start_wr) begin
                        blur_start <= 1'b1;
                        done       <= 1'b0;
                        seq        <= SQ_BLUR;
                    end
                end
                SQ_BLUR: begin
                    if (blur_done) begin
                        detect_start <= 1'b1;
                        seq          <= SQ_DETECT;
                    end
                end
                SQ_DETECT: begin
                    if (detect_done) begin
                        done <= 1'b1;
                        seq  <= SQ_IDLE;
                    end
                end
                default: seq <= SQ_IDLE;
            endcase
        end
    end

endmodule

/* hw/row_mem_arbiter.sv */
`timescale 1ns/100ps

module row_mem_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [feature_pkg::N_REQ-1:0] req,
    input  logic [feature_pkg::N_REQ-1:0] we,
    input  feature_pkg::row_addr_t        addr [feature_pkg::N_REQ],
    input  feature_pkg::row_t             wdata [feature_pkg::N_REQ],
    output logic [feature_pkg::N_REQ-1:0] gnt,
    output feature_pkg::row_t             rdata
);

    int sel;

    // lowest index wins
    always_comb begin
        sel = 0;
        for (int i = feature_pkg::N_REQ - 1; i >= 0; i--) begin
            if (req[i])
                sel = i;
        end
        gnt = '0;
        gnt[sel] = req[sel];
    end

    sp_ram #(
        .word_t (feature_pkg::row_t),
        .DEPTH  (2 ** feature_pkg::ROW_AW)
    ) i_row_ram (
        .clk   (clk),
        .we    (gnt[sel] && we[sel] && rst_n),
        .addr  (addr[sel]),
        .wdata (wdata[sel]),
        .rdata (rdata)
    );

endmodule

/* hw/sp_ram.sv */
`timescale 1ns/100ps

module sp_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    wdata,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];                            // old data on a write
    end

endmodule

/* hw/feature_pkg.sv */
package feature_pkg;

    localparam int IMG_W     = 16;
    localparam int IMG_H     = 16;
    localparam int PIX_W     = 8;
    localparam int ROW_AW    = 5;
    localparam int BLUR_BASE = 16;                     // rows 0..15 hold the image
    localparam int KPT_DEPTH = 64;
    localparam int KPT_AW    = 6;
    localparam int AXI_AW    = 12;
    localparam int AXI_DW    = 32;
    localparam int N_REQ     = 3;                      // host, blur, detect

    typedef logic [IMG_W*PIX_W-1:0] row_t;            // pixel 0 in the low byte
    typedef logic [ROW_AW-1:0]      row_addr_t;
    typedef logic [7:0]             kpt_t;            // {row, col}
    typedef logic [KPT_AW:0]        kpt_cnt_t;

    localparam logic [AXI_AW-1:0] REG_CTRL    = 12'h000;
    localparam logic [AXI_AW-1:0] REG_STATUS  = 12'h004;
    localparam logic [AXI_AW-1:0] REG_THRESH  = 12'h008;
    localparam logic [AXI_AW-1:0] REG_KPT_CNT = 12'h00C;
    localparam logic [AXI_AW-1:0] ROW_WIN     = 12'h200; // row a, lane l at +16a+4l
    localparam logic [AXI_AW-1:0] KPT_WIN     = 12'h400; // entry i at +4i

endpackage
